// File: axi_pkg.sv
//----------------------------------------
// AXI types for single-beat, full-word transfers
// 32-bit address and data only
//----------------------------------------
package axi_pkg;

    // Byte address on both address channels
    typedef logic [31:0] axi_addr_t;

    // One full data word, all strobes implied
    typedef logic [31:0] axi_data_t;

    // Address stride between neighbouring words
    localparam axi_addr_t WORD_BYTES = 32'd4;

endpackage

// File: mpad_pkg.sv
//----------------------------------------
// Matrix geometry and 2x2 block data types
// Source width must be even, 2 to 60
//----------------------------------------
package mpad_pkg;

    import axi_pkg::*;

    localparam int MIN_WIDTH = 2;
    localparam int MAX_WIDTH = 60;
    localparam int WIN_SIDE  = 3;  // 3x3 neighbourhood
    localparam int WIN_ELEMS = WIN_SIDE * WIN_SIDE;

    // Row-major index into the 3x3 window
    typedef logic [3:0] win_idx_t;

    typedef struct packed {
        axi_addr_t src_base;
        axi_addr_t dst_base;
    } dma_cfg_t;

    // Output words of one block
    typedef struct packed {
        axi_data_t tl;
        axi_data_t tr;
        axi_data_t bl;
        axi_data_t br;
    } quad_t;

    // Bit 1 is the row step, bit 0 the column step
    typedef enum logic [1:0] {
        SIDE_TL = 2'd0,
        SIDE_TR = 2'd1,
        SIDE_BL = 2'd2,
        SIDE_BR = 2'd3
    } blk_side_e;

endpackage

// File: mirror_addr_gen.sv
`timescale 1ns/1ps
//----------------------------------------
// Source address of one 3x3 window element
// Coordinates clamp into 1..width
//----------------------------------------
module mirror_addr_gen import axi_pkg::*; import mpad_pkg::*; #(
    parameter int DIM_W = 7
) (
    input  axi_addr_t        src_base_i,
    input  logic [DIM_W-1:0] width_i,
    input  logic [DIM_W-1:0] blk_row_i,
    input  logic [DIM_W-1:0] blk_col_i,
    input  win_idx_t         elem_i,
    output axi_addr_t        addr_o
);

    localparam logic signed [DIM_W:0] ONE_S = 1;

    logic signed [DIM_W:0] row_off;
    logic signed [DIM_W:0] col_off;
    logic signed [DIM_W:0] row_tgt;
    logic signed [DIM_W:0] col_tgt;
    logic [DIM_W-1:0]      row_src;
    logic [DIM_W-1:0]      col_src;
    axi_addr_t             word_idx;

    function automatic logic [DIM_W-1:0] clamp_coord(
        input logic signed [DIM_W:0] tgt,
        input logic [DIM_W-1:0]      wid
    );
        logic signed [DIM_W:0] wid_s;
        wid_s = signed'({1'b0, wid});
        if (tgt < ONE_S) begin
            return DIM_W'(1);  // Top or left border
        end else if (tgt > wid_s) begin
            return wid;        // Bottom or right border
        end
        return tgt[DIM_W-1:0];
    endfunction

    always_comb begin
        // Offsets -1..+1 around the centre at origin+1
        row_off  = (DIM_W+1)'(elem_i / WIN_SIDE) - ONE_S;
        col_off  = (DIM_W+1)'(elem_i % WIN_SIDE) - ONE_S;
        row_tgt  = (DIM_W+1)'(blk_row_i) + ONE_S + row_off;
        col_tgt  = (DIM_W+1)'(blk_col_i) + ONE_S + col_off;
        row_src  = clamp_coord(row_tgt, width_i);
        col_src  = clamp_coord(col_tgt, width_i);
        word_idx = axi_addr_t'(row_src - 1'b1) * axi_addr_t'(width_i)
                 + axi_addr_t'(col_src - 1'b1);
        addr_o   = src_base_i + word_idx * WORD_BYTES;
    end

endmodule

// File: tile_fetch.sv
`timescale 1ns/1ps
//----------------------------------------
// Nine single AXI reads fill the 3x3 window
// Origin and width held while fetch_req_i is high
//----------------------------------------
module tile_fetch import axi_pkg::*; import mpad_pkg::*; #(
    parameter int DIM_W = 7
) (
    input  logic             clk,
    input  logic             rst_n,
    input  dma_cfg_t         cfg_i,
    input  logic [DIM_W-1:0] width_i,
    input  logic [DIM_W-1:0] blk_row_i,
    input  logic [DIM_W-1:0] blk_col_i,
    input  logic             fetch_req_i,
    output logic             fetch_ack_o,
    output quad_t            quad_o,
    output axi_addr_t        ar_addr_o,
    output logic             ar_valid_o,
    input  logic             ar_ready_i,
    input  axi_data_t        r_data_i,
    input  logic             r_valid_i,
    output logic             r_ready_o
);

    typedef enum logic [1:0] {
        FT_IDLE,
        FT_ADDR,
        FT_DATA,
        FT_ACK
    } fetch_state_e;

    fetch_state_e state_q;
    win_idx_t     elem_q;
    axi_data_t    win_q [WIN_ELEMS];
    logic [1:0]   row0;
    logic [1:0]   row1;
    logic [1:0]   col0;
    logic [1:0]   col1;

    // Window row/col holding output coordinate out_c
    function automatic logic [1:0] win_pos(
        input logic [DIM_W-1:0] out_c,
        input logic [DIM_W-1:0] org,
        input logic [DIM_W-1:0] wid
    );
        logic [DIM_W-1:0] src;
        if (out_c == '0) begin
            src = DIM_W'(1);
        end else if (out_c > wid) begin
            src = wid;
        end else begin
            src = out_c;
        end
        return 2'(src - org);
    endfunction

    function automatic win_idx_t win_idx(input logic [1:0] r, input logic [1:0] c);
        return win_idx_t'(r) * win_idx_t'(WIN_SIDE) + win_idx_t'(c);
    endfunction

    mirror_addr_gen #(.DIM_W(DIM_W)) i_addr_gen (
        .src_base_i (cfg_i.src_base),
        .width_i    (width_i),
        .blk_row_i  (blk_row_i),
        .blk_col_i  (blk_col_i),
        .elem_i     (elem_q),
        .addr_o     (ar_addr_o)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= FT_IDLE;
            elem_q  <= '0;
        end else begin
            unique case (state_q)
                FT_IDLE: begin
                    if (fetch_req_i) begin
                        elem_q  <= '0;
                        state_q <= FT_ADDR;
                    end
                end
                FT_ADDR: if (ar_ready_i) state_q <= FT_DATA;
                FT_DATA: begin
                    if (r_valid_i) begin
                        if (elem_q == win_idx_t'(WIN_ELEMS - 1)) begin
                            state_q <= FT_ACK;
                        end else begin
                            elem_q  <= elem_q + 1'b1;
                            state_q <= FT_ADDR;  // Next element of the window
                        end
                    end
                end
                FT_ACK: if (!fetch_req_i) state_q <= FT_IDLE;
                default: state_q <= FT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FT_DATA && r_valid_i) begin
            win_q[elem_q] <= r_data_i;
        end
    end

    assign ar_valid_o  = (state_q == FT_ADDR);
    assign r_ready_o   = (state_q == FT_DATA);
    assign fetch_ack_o = (state_q == FT_ACK);

    assign row0 = win_pos(blk_row_i, blk_row_i, width_i);
    assign row1 = win_pos(blk_row_i + 1'b1, blk_row_i, width_i);
    assign col0 = win_pos(blk_col_i, blk_col_i, width_i);
    assign col1 = win_pos(blk_col_i + 1'b1, blk_col_i, width_i);

    always_comb begin
        quad_o.tl = win_q[win_idx(row0, col0)];
        quad_o.tr = win_q[win_idx(row0, col1)];
        quad_o.bl = win_q[win_idx(row1, col0)];
        quad_o.br = win_q[win_idx(row1, col1)];
    end

    // Relies on the sequencer holding the origin during the request
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else $error("AR address changed under stall");

endmodule

// File: block_store.sv
`timescale 1ns/1ps
//----------------------------------------
// Four single AXI writes of one 2x2 block
// Slave must not answer B before W is taken
//----------------------------------------
module block_store import axi_pkg::*; import mpad_pkg::*; #(
    parameter int DIM_W = 7
) (
    input  logic             clk,
    input  logic             rst_n,
    input  axi_addr_t        dst_base_i,
    input  logic [DIM_W-1:0] width_i,
    input  logic [DIM_W-1:0] blk_row_i,
    input  logic [DIM_W-1:0] blk_col_i,
    input  logic             store_req_i,
    input  quad_t            quad_i,
    output logic             store_ack_o,
    output axi_addr_t        aw_addr_o,
    output logic             aw_valid_o,
    input  logic             aw_ready_i,
    output axi_data_t        w_data_o,
    output logic             w_valid_o,
    input  logic             w_ready_i,
    input  logic             b_valid_i,
    output logic             b_ready_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_AW,
        ST_WB,
        ST_ACK
    } store_state_e;

    store_state_e state_q;
    blk_side_e    side_q;
    logic         w_valid_q;
    axi_addr_t    out_row;
    axi_addr_t    out_col;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            side_q    <= SIDE_TL;
            w_valid_q <= 1'b0;
        end else begin
            unique case (state_q)
                ST_IDLE: begin
                    if (store_req_i) begin
                        side_q  <= SIDE_TL;
                        state_q <= ST_AW;
                    end
                end
                ST_AW: begin
                    if (aw_ready_i) begin
                        w_valid_q <= 1'b1;
                        state_q   <= ST_WB;
                    end
                end
                ST_WB: begin
                    if (w_ready_i) w_valid_q <= 1'b0;
                    if (b_valid_i) begin
                        if (side_q == SIDE_BR) begin
                            state_q <= ST_ACK;  // Whole block written
                        end else begin
                            side_q  <= side_q.next();
                            state_q <= ST_AW;
                        end
                    end
                end
                ST_ACK: if (!store_req_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Row-major position in the padded (width+2) square
    assign out_row   = axi_addr_t'(blk_row_i) + axi_addr_t'(side_q[1]);
    assign out_col   = axi_addr_t'(blk_col_i) + axi_addr_t'(side_q[0]);
    assign aw_addr_o = dst_base_i
                     + (out_row * (axi_addr_t'(width_i) + 32'd2) + out_col) * WORD_BYTES;

    always_comb begin
        unique case (side_q)
            SIDE_TL: w_data_o = quad_i.tl;
            SIDE_TR: w_data_o = quad_i.tr;
            SIDE_BL: w_data_o = quad_i.bl;
            default: w_data_o = quad_i.br;
        endcase
    end

    assign aw_valid_o  = (state_q == ST_AW);
    assign w_valid_o   = w_valid_q;
    assign b_ready_o   = (state_q == ST_WB);
    assign store_ack_o = (state_q == ST_ACK);

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else $error("AW address changed under stall");

    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
        else $error("W data changed under stall");

    a_w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o |-> !w_valid_o)
        else $error("W valid while its AW is still pending");

endmodule

// File: pad_sequencer.sv
`timescale 1ns/1ps
//----------------------------------------
// Walks 2x2 output blocks, row by row
// start_i must drop before the next run
//----------------------------------------
module pad_sequencer import mpad_pkg::*; #(
    parameter int DIM_W = 7
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_i,
    input  dma_cfg_t         cfg_i,
    input  logic [DIM_W-1:0] width_i,
    output logic             done_o,
    output dma_cfg_t         cfg_o,
    output logic [DIM_W-1:0] width_o,
    output logic [DIM_W-1:0] blk_row_o,
    output logic [DIM_W-1:0] blk_col_o,
    output logic             fetch_req_o,
    input  logic             fetch_ack_i,
    input  quad_t            quad_i,
    output logic             store_req_o,
    output quad_t            quad_o,
    input  logic             store_ack_i
);

    typedef enum logic [2:0] {
        SQ_IDLE,
        SQ_FETCH,
        SQ_STORE,
        SQ_NEXT,
        SQ_DONE
    } seq_state_e;

    seq_state_e state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= SQ_IDLE;
            done_o      <= 1'b1;
            blk_row_o   <= '0;
            blk_col_o   <= '0;
            fetch_req_o <= 1'b0;
            store_req_o <= 1'b0;
        end else begin
            unique case (state_q)
                SQ_IDLE: begin
                    if (start_i) begin
                        done_o      <= 1'b0;
                        blk_row_o   <= '0;
                        blk_col_o   <= '0;
                        fetch_req_o <= 1'b1;
                        state_q     <= SQ_FETCH;
                    end
                end
                SQ_FETCH: begin
                    if (fetch_req_o && fetch_ack_i) begin
                        fetch_req_o <= 1'b0;
                    end else if (!fetch_req_o && !fetch_ack_i) begin
                        store_req_o <= 1'b1;  // Fetch handshake closed
                        state_q     <= SQ_STORE;
                    end
                end
                SQ_STORE: begin
                    if (store_req_o && store_ack_i) begin
                        store_req_o <= 1'b0;
                    end else if (!store_req_o && !store_ack_i) begin
                        state_q <= SQ_NEXT;
                    end
                end
                SQ_NEXT: begin
                    if (blk_col_o != width_o) begin
                        blk_col_o   <= blk_col_o + DIM_W'(2);
                        fetch_req_o <= 1'b1;
                        state_q     <= SQ_FETCH;
                    end else if (blk_row_o != width_o) begin
                        blk_col_o   <= '0;
                        blk_row_o   <= blk_row_o + DIM_W'(2);
                        fetch_req_o <= 1'b1;
                        state_q     <= SQ_FETCH;
                    end else begin
                        done_o  <= 1'b1;  // Block at (width, width) was the last
                        state_q <= SQ_DONE;
                    end
                end
                SQ_DONE: if (!start_i) state_q <= SQ_IDLE;
                default: state_q <= SQ_IDLE;
            endcase
        end
    end

    // Configuration and block data
    always_ff @(posedge clk) begin
        if (state_q == SQ_IDLE && start_i) begin
            cfg_o   <= cfg_i;
            width_o <= width_i;
        end
        if (fetch_req_o && fetch_ack_i) quad_o <= quad_i;
    end

    a_width_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == SQ_IDLE && start_i |->
            !width_i[0] && width_i >= DIM_W'(MIN_WIDTH) && width_i <= DIM_W'(MAX_WIDTH))
        else $error("Illegal width %0d at start", width_i);

endmodule

// File: mirror_pad_dma.sv
`timescale 1ns/1ps
//----------------------------------------
// Mirror-pad DMA, one AXI transaction in flight
// Even width 2..60, DIM_W must hold width+1
//----------------------------------------
module mirror_pad_dma import axi_pkg::*; import mpad_pkg::*; #(
    parameter int DIM_W = 7
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_i,
    input  dma_cfg_t         cfg_i,
    input  logic [DIM_W-1:0] width_i,
    output logic             done_o,
    output axi_addr_t        ar_addr_o,
    output logic             ar_valid_o,
    input  logic             ar_ready_i,
    input  axi_data_t        r_data_i,
    input  logic             r_valid_i,
    output logic             r_ready_o,
    output axi_addr_t        aw_addr_o,
    output logic             aw_valid_o,
    input  logic             aw_ready_i,
    output axi_data_t        w_data_o,
    output logic             w_valid_o,
    input  logic             w_ready_i,
    input  logic             b_valid_i,
    output logic             b_ready_o
);

    dma_cfg_t         cfg;
    logic [DIM_W-1:0] width;
    logic [DIM_W-1:0] blk_row;
    logic [DIM_W-1:0] blk_col;
    logic             fetch_req;
    logic             fetch_ack;
    quad_t            fetch_quad;
    logic             store_req;
    logic             store_ack;
    quad_t            store_quad;

    pad_sequencer #(.DIM_W(DIM_W)) i_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .cfg_i       (cfg_i),
        .width_i     (width_i),
        .done_o      (done_o),
        .cfg_o       (cfg),
        .width_o     (width),
        .blk_row_o   (blk_row),
        .blk_col_o   (blk_col),
        .fetch_req_o (fetch_req),
        .fetch_ack_i (fetch_ack),
        .quad_i      (fetch_quad),
        .store_req_o (store_req),
        .quad_o      (store_quad),
        .store_ack_i (store_ack)
    );

    tile_fetch #(.DIM_W(DIM_W)) i_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_i       (cfg),
        .width_i     (width),
        .blk_row_i   (blk_row),
        .blk_col_i   (blk_col),
        .fetch_req_i (fetch_req),
        .fetch_ack_o (fetch_ack),
        .quad_o      (fetch_quad),
        .ar_addr_o   (ar_addr_o),
        .ar_valid_o  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .r_data_i    (r_data_i),
        .r_valid_i   (r_valid_i),
        .r_ready_o   (r_ready_o)
    );

    block_store #(.DIM_W(DIM_W)) i_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .dst_base_i  (cfg.dst_base),
        .width_i     (width),
        .blk_row_i   (blk_row),
        .blk_col_i   (blk_col),
        .store_req_i (store_req),
        .quad_i      (store_quad),
        .store_ack_o (store_ack),
        .aw_addr_o   (aw_addr_o),
        .aw_valid_o  (aw_valid_o),
        .aw_ready_i  (aw_ready_i),
        .w_data_o    (w_data_o),
        .w_valid_o   (w_valid_o),
        .w_ready_i   (w_ready_i),
        .b_valid_i   (b_valid_i),
        .b_ready_o   (b_ready_o)
    );

endmodule

// File: tb_axi_mem.sv
`timescale 1ns/1ps
//----------------------------------------
// AXI slave memory of 8K words for the testbench
// Ready and responses stall 0..3 cycles at random
//----------------------------------------
module tb_axi_mem import axi_pkg::*; #(
    parameter int          WORDS = 8192,
    parameter logic [31:0] SEED  = 32'h464f9362
) (
    input  logic      clk,
    input  axi_addr_t ar_addr_i,
    input  logic      ar_valid_i,
    output logic      ar_ready_o,
    output axi_data_t r_data_o,
    output logic      r_valid_o,
    input  logic      r_ready_i,
    input  axi_addr_t aw_addr_i,
    input  logic      aw_valid_i,
    output logic      aw_ready_o,
    input  axi_data_t w_data_i,
    input  logic      w_valid_i,
    output logic      w_ready_o,
    output logic      b_valid_o,
    input  logic      b_ready_i
);

    axi_data_t   mem    [WORDS];  // Preloaded by the test top
    int unsigned wr_cnt [WORDS];  // Writes seen per word
    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int word_index(input axi_addr_t addr);
        return int'((addr >> 2) % WORDS);
    endfunction

    function automatic int next_delay();
        rng = xorshift32(rng);
        return int'(rng[1:0]);
    endfunction

    initial begin
        logic      ar_fire, r_fire, aw_fire, w_fire, b_fire;
        axi_addr_t ar_addr_s, aw_addr_s, rd_addr, wr_addr;
        axi_data_t w_data_s;
        logic      r_pend, b_pend;
        int        ar_wait, r_wait, aw_wait, w_wait, b_wait;
        rng        = SEED;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        r_pend     = 1'b0;
        b_pend     = 1'b0;
        rd_addr    = '0;
        wr_addr    = '0;
        for (int i = 0; i < WORDS; i++) wr_cnt[i] = 0;
        ar_wait = next_delay();
        aw_wait = next_delay();
        w_wait  = next_delay();
        r_wait  = 0;
        b_wait  = 0;
        forever begin
            @(posedge clk);
            ar_fire   = ar_valid_i && ar_ready_o;  // Handshakes of this edge
            r_fire    = r_valid_o && r_ready_i;
            aw_fire   = aw_valid_i && aw_ready_o;
            w_fire    = w_valid_i && w_ready_o;
            b_fire    = b_valid_o && b_ready_i;
            ar_addr_s = ar_addr_i;
            aw_addr_s = aw_addr_i;
            w_data_s  = w_data_i;
            #1;
            ar_ready_o = 1'b0;
            aw_ready_o = 1'b0;
            w_ready_o  = 1'b0;
            if (r_fire) r_valid_o = 1'b0;
            if (b_fire) b_valid_o = 1'b0;
            if (aw_fire) wr_addr = aw_addr_s;
            if (ar_fire) begin
                rd_addr = ar_addr_s;
                r_pend  = 1'b1;
                r_wait  = next_delay();
            end
            if (w_fire) begin
                mem[word_index(wr_addr)] = w_data_s;
                wr_cnt[word_index(wr_addr)]++;
                b_pend = 1'b1;  // B only after W was taken
                b_wait = next_delay();
            end
            if (ar_valid_i) begin
                if (ar_wait == 0) begin
                    ar_ready_o = 1'b1;
                    ar_wait    = next_delay();
                end else ar_wait--;
            end
            if (aw_valid_i) begin
                if (aw_wait == 0) begin
                    aw_ready_o = 1'b1;
                    aw_wait    = next_delay();
                end else aw_wait--;
            end
            if (w_valid_i) begin
                if (w_wait == 0) begin
                    w_ready_o = 1'b1;
                    w_wait    = next_delay();
                end else w_wait--;
            end
            if (r_pend) begin
                if (r_wait == 0) begin
                    r_valid_o = 1'b1;
                    r_data_o  = mem[word_index(rd_addr)];
                    r_pend    = 1'b0;
                end else r_wait--;
            end
            if (b_pend) begin
                if (b_wait == 0) begin
                    b_valid_o = 1'b1;
                    b_pend    = 1'b0;
                end else b_wait--;
            end
        end
    end

endmodule

// File: tb_mirror_pad_dma.sv
`timescale 1ns/1ps
//----------------------------------------
// Testbench for mirror_pad_dma
// Each run waits on done_o with its own timeout
//----------------------------------------
module tb_mirror_pad_dma import axi_pkg::*, mpad_pkg::*; ();

    localparam int DIM_W       = 7;
    localparam int TIMEOUT_CYC = 20000;
    localparam int MEM_WORDS   = 8192;

    logic             clk;
    logic             rst_n;
    logic             start_i;
    dma_cfg_t         cfg_i;
    logic [DIM_W-1:0] width_i;
    logic             done_o;
    axi_addr_t        ar_addr_o, aw_addr_o;
    axi_data_t        r_data_i, w_data_o;
    logic             ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
    logic             aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;
    axi_addr_t        src_bytes, dst_bytes;
    logic             armed_q;  // Sequencer is idle and may take a start
    int               err_cnt   = 0;
    int               test_cnt  = 0;
    bit               timed_out = 1'b0;

    mirror_pad_dma #(.DIM_W(DIM_W)) i_dut (.*);

    tb_axi_mem #(.WORDS(MEM_WORDS), .SEED(32'h464f9362)) i_mem (
        .clk        (clk),
        .ar_addr_i  (ar_addr_o),
        .ar_valid_i (ar_valid_o),
        .ar_ready_o (ar_ready_i),
        .r_data_o   (r_data_i),
        .r_valid_o  (r_valid_i),
        .r_ready_i  (r_ready_o),
        .aw_addr_i  (aw_addr_o),
        .aw_valid_i (aw_valid_o),
        .aw_ready_o (aw_ready_i),
        .w_data_i   (w_data_o),
        .w_valid_i  (w_valid_o),
        .w_ready_o  (w_ready_i),
        .b_valid_o  (b_valid_i),
        .b_ready_i  (b_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign src_bytes = axi_addr_t'(width_i) * axi_addr_t'(width_i) * WORD_BYTES;
    assign dst_bytes = (axi_addr_t'(width_i) + 32'd2) * (axi_addr_t'(width_i) + 32'd2) * WORD_BYTES;

    always_ff @(posedge clk) begin
        if (!rst_n) armed_q <= 1'b1;
        else if (!start_i) armed_q <= 1'b1;
        else if (done_o) armed_q <= 1'b0;
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |=>
        done_o && !ar_valid_o && !r_ready_o && !aw_valid_o && !w_valid_o && !b_ready_o)
        else begin
            err_cnt++;
            $display("%0t: done_o low or a valid/ready output high after reset", $time);
        end

    a_start_taken: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && start_i && armed_q |=> !done_o)
        else begin
            err_cnt++;
            $display("%0t: start accepted but done_o did not fall", $time);
        end

    a_start_held: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && start_i && !armed_q |=> done_o)
        else begin
            err_cnt++;
            $display("%0t: new run began before start_i went low", $time);
        end

    a_ar_in_src: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o |-> ar_addr_o[1:0] == 2'b00 && ar_addr_o >= cfg_i.src_base
            && ar_addr_o - cfg_i.src_base < src_bytes)
        else begin
            err_cnt++;
            $display("ERROR %0t ar_addr_o: got %h, expected aligned in %h..%h", $time,
                     ar_addr_o, cfg_i.src_base, cfg_i.src_base + src_bytes - 32'd4);
        end

    a_aw_in_dst: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o |-> aw_addr_o[1:0] == 2'b00 && aw_addr_o >= cfg_i.dst_base
            && aw_addr_o - cfg_i.dst_base < dst_bytes)
        else begin
            err_cnt++;
            $display("ERROR %0t aw_addr_o: got %h, expected aligned in %h..%h", $time,
                     aw_addr_o, cfg_i.dst_base, cfg_i.dst_base + dst_bytes - 32'd4);
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else begin
            err_cnt++;
            $display("%0t: AR request dropped or changed before it was accepted", $time);
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else begin
            err_cnt++;
            $display("%0t: AW request dropped or changed before it was accepted", $time);
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
        else begin
            err_cnt++;
            $display("%0t: W data dropped or changed before it was accepted", $time);
        end

    // Source contents, a function of the whole word index
    function automatic axi_data_t src_pattern(input int idx);
        return (axi_data_t'(idx) * 32'h9e3779b1) ^ 32'h5ca1ab1e;
    endfunction

    // Padded coordinate to source coordinate, 1-based
    function automatic int mirror_coord(input int x, input int w);
        if (x == 0) return 1;
        if (x > w) return w;
        return x;
    endfunction

    task automatic check_region(input axi_addr_t src, input axi_addr_t dst, input int w);
        int        d_idx;
        int        s_idx;
        axi_data_t exp_val;
        for (int r = 0; r < w + 2; r++) begin
            for (int c = 0; c < w + 2; c++) begin
                d_idx   = int'(dst >> 2) + r * (w + 2) + c;
                s_idx   = int'(src >> 2) + (mirror_coord(r, w) - 1) * w + mirror_coord(c, w) - 1;
                exp_val = src_pattern(s_idx);
                assert (i_mem.wr_cnt[d_idx] == 1) else begin
                    err_cnt++;
                    $display("ERROR %0t i_mem.wr_cnt[%0d]: got %0d, expected 1", $time,
                             d_idx, i_mem.wr_cnt[d_idx]);
                end
                assert (i_mem.mem[d_idx] == exp_val) else begin
                    err_cnt++;
                    $display("ERROR %0t i_mem.mem[%0d]: got %h, expected %h", $time,
                             d_idx, i_mem.mem[d_idx], exp_val);
                end
            end
        end
    endtask

    task automatic wait_done(input logic lvl, output bit ok);
        ok = 1'b0;
        for (int cnt = 0; cnt < TIMEOUT_CYC; cnt++) begin
            @(posedge clk);
            #1;
            if (done_o == lvl) begin
                ok = 1'b1;
                return;
            end
        end
        $display("timeout, done_o did not go to %0b within %0d cycles", lvl, TIMEOUT_CYC);
        timed_out = 1'b1;
    endtask

    task automatic report_test(input string name, input int err0);
        if (err_cnt == err0 && !timed_out) begin
            $display("test %0d, %s: passed", test_cnt, name);
        end else begin
            $display("test %0d, %s: failed with %0d errors", test_cnt, name, err_cnt - err0);
        end
    endtask

    task automatic run_case(input string name, input axi_addr_t src, input axi_addr_t dst,
                            input int w);
        int err0;
        bit ok;
        err0 = err_cnt;
        test_cnt++;
        @(posedge clk);
        #1;
        cfg_i.src_base = src;
        cfg_i.dst_base = dst;
        width_i        = DIM_W'(w);
        start_i        = 1'b1;
        wait_done(1'b0, ok);
        if (ok) wait_done(1'b1, ok);
        if (ok) begin
            repeat (3) @(posedge clk);  // Start still high, no new run
            #1;
            start_i = 1'b0;
            check_region(src, dst, w);
        end
        report_test(name, err0);
    endtask

    initial begin
        int err0;
        rst_n   = 1'b0;
        start_i = 1'b0;
        cfg_i   = '0;
        width_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) i_mem.mem[i] = src_pattern(i);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_case("width 2", 32'h0000_1000, 32'h0000_2000, 2);
        if (!timed_out) run_case("width 6 back to back", 32'h0000_3000, 32'h0000_4000, 6);
        if (!timed_out) begin
            err0 = err_cnt;
            test_cnt++;
            check_region(32'h0000_1000, 32'h0000_2000, 2);  // First copy intact
            report_test("first region after second run", err0);
        end
        $display("tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (timed_out || err_cnt != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// File: filelist.f
axi_pkg.sv
mpad_pkg.sv
mirror_addr_gen.sv
tile_fetch.sv
block_store.sv
pad_sequencer.sv
mirror_pad_dma.sv
tb_axi_mem.sv
tb_mirror_pad_dma.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_mirror_pad_dma \
    -f filelist.f && ./obj_dir/Vtb_mirror_pad_dma 2>&1 | tee sim.log || exit 1
# The log decides pass or fail
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
